// File: hdl/port_decode.sv
`timescale 1ns/1ns

module port_decode (
	input logic clk,
	input logic interrupt_rst,
	input uart_io_pkg::port_addr_t port_id,
	input logic write_strobe,
	input logic read_strobe,
	input uart_io_pkg::byte_t out_port,
	output uart_io_pkg::port_req_t port_req
);
	import uart_io_pkg::*;

	// raw address matches
	logic hit_uart;
	logic hit_irq;
	logic hit_status;
	logic hit_ext;
	port_req_t req_next;

	assign hit_uart = (port_id == PORT_UART);
	assign hit_irq = (port_id == PORT_IRQ);
	assign hit_status = (port_id == PORT_STATUS);
	// external window includes both ends
	assign hit_ext = (port_id >= PORT_EXT_LO) && (port_id <= PORT_EXT_HI);

	always_comb begin
		req_next = '0;
		// write effects need the strobe
		req_next.wr_tx = write_strobe && hit_uart;
		req_next.irq_clear = write_strobe && hit_irq;
		// reading the uart port consumes the byte
		req_next.rx_ack = read_strobe && hit_uart;
		// read selects are address only
		req_next.sel_rx = hit_uart;
		req_next.sel_irq = hit_irq;
		req_next.sel_status = hit_status;
		req_next.sel_ext = hit_ext;
		req_next.wr_data = out_port;
	end

	// one request per clock into stage two
	always_ff @(posedge clk) begin
		if (interrupt_rst) begin
			port_req <= '0;
		end else begin
			port_req <= req_next;
		end
	end

	// two write targets never in one request
	assert property (@(posedge clk) disable iff (interrupt_rst)
		!(port_req.wr_tx && port_req.irq_clear));

endmodule

// File: hdl/port_regs.sv
`timescale 1ns/1ns

module port_regs (
	input logic clk,
	input logic interrupt_rst,
	input uart_io_pkg::port_req_t port_req,
	input uart_io_pkg::byte_t ext_data_in,
	input uart_io_pkg::byte_t rx_byte,
	input logic rx_valid,
	input logic tx_done,
	input logic ext_int,
	output logic tx_start,
	output uart_io_pkg::byte_t tx_byte,
	output uart_io_pkg::byte_t in_port,
	output logic interrupt
);
	import uart_io_pkg::*;

	byte_t rx_hold;
	logic rx_ready;
	logic tx_busy;
	logic tx_accept;
	irq_flags_t irq_flags;
	byte_t read_data;

	// one-byte receive holding register
	// a new byte overwrites an unread one
	always_ff @(posedge clk) begin
		if (rx_valid) begin
			rx_hold <= rx_byte;
		end
	end

	// ready latch, new byte beats the ack
	always_ff @(posedge clk) begin
		if (interrupt_rst) begin
			rx_ready <= 1'b0;
		end else if (rx_valid) begin
			rx_ready <= 1'b1;
		end else if (port_req.rx_ack) begin
			rx_ready <= 1'b0;
		end
	end

	// writes during a frame are dropped
	assign tx_accept = port_req.wr_tx && !tx_busy;

	// launch pulse and busy flag
	always_ff @(posedge clk) begin
		if (interrupt_rst) begin
			tx_start <= 1'b0;
			tx_busy <= 1'b0;
		end else begin
			tx_start <= tx_accept;
			if (tx_accept) begin
				tx_busy <= 1'b1;
			end else if (tx_done) begin
				tx_busy <= 1'b0;
			end
		end
	end

	// byte handed to the transmitter
	always_ff @(posedge clk) begin
		if (tx_accept) begin
			tx_byte <= port_req.wr_data;
		end
	end

	// sticky flags, port clear wins
	always_ff @(posedge clk) begin
		if (interrupt_rst || port_req.irq_clear) begin
			irq_flags <= '0;
		end else begin
			if (rx_ready) begin
				irq_flags[IRQ_RX] <= 1'b1;
			end
			if (tx_done) begin
				irq_flags[IRQ_TX] <= 1'b1;
			end
			if (ext_int) begin
				irq_flags[IRQ_EXT] <= 1'b1;
			end
		end
	end

	// interrupt line to the core
	always_ff @(posedge clk) begin
		if (interrupt_rst) begin
			interrupt <= 1'b0;
		end else begin
			interrupt <= |irq_flags[5:0];
		end
	end

	// read mux, selects are one-hot by address
	always_comb begin
		read_data = NO_DATA;
		if (port_req.sel_rx) begin
			read_data = rx_hold;
		end else if (port_req.sel_irq) begin
			read_data = irq_flags;
		end else if (port_req.sel_status) begin
			read_data = {7'b0, tx_busy};
		end else if (port_req.sel_ext) begin
			// external data taken live here
			read_data = ext_data_in;
		end
	end

	always_ff @(posedge clk) begin
		if (interrupt_rst) begin
			in_port <= NO_DATA;
		end else begin
			in_port <= read_data;
		end
	end

	// launch only from an idle transmitter
	assert property (@(posedge clk) disable iff (interrupt_rst)
		tx_start |-> !$past(tx_busy));

	// the transmitter only finishes frames started here
	assert property (@(posedge clk) disable iff (interrupt_rst)
		tx_done |-> tx_busy);

endmodule

// File: hdl/uart_io_pkg.sv
package uart_io_pkg;

	// bus and serial payload
	typedef logic [7:0] byte_t;
	// port number on the bus
	typedef logic [7:0] port_addr_t;
	// sticky interrupt register
	typedef logic [7:0] irq_flags_t;

	// irq bit positions, unlisted bits stay 0
	localparam int IRQ_RX = 0;
	localparam int IRQ_TX = 1;
	localparam int IRQ_EXT = 3;

	// port map
	// write sends, read returns received byte
	localparam port_addr_t PORT_UART = 8'h00;
	// write clears flags, read returns them
	localparam port_addr_t PORT_IRQ = 8'h03;
	// bit 0 is tx busy
	localparam port_addr_t PORT_STATUS = 8'h07;
	// external bus window
	localparam port_addr_t PORT_EXT_LO = 8'h10;
	localparam port_addr_t PORT_EXT_HI = 8'h7f;

	// unmapped ports read as all ones
	localparam byte_t NO_DATA = 8'hff;

	// decoded bus access, stage one to stage two
	typedef struct packed {
		logic wr_tx;
		logic irq_clear;
		logic rx_ack;
		logic sel_rx;
		logic sel_irq;
		logic sel_status;
		logic sel_ext;
		byte_t wr_data;
	} port_req_t;

	typedef enum logic [1:0] {RX_IDLE, RX_SHIFT, RX_DONE} rx_state_t;
	typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;

endpackage

// File: hdl/uart_io_top.sv
`timescale 1ns/1ns

module uart_io_top #(
	parameter int clk_freq = 50_000_000,
	parameter int baud_rate = 115_200
) (
	input logic clk,
	input logic interrupt_rst,
	input uart_io_pkg::port_addr_t port_id,
	input logic write_strobe,
	input logic read_strobe,
	input uart_io_pkg::byte_t out_port,
	input uart_io_pkg::byte_t ext_data_in,
	input logic serial_in,
	input logic ext_int,
	output uart_io_pkg::byte_t in_port,
	output logic serial_out,
	output logic interrupt
);
	import uart_io_pkg::*;

	// stage one to stage two
	port_req_t port_req;
	// register block to and from the uarts
	logic tx_start;
	byte_t tx_byte;
	logic tx_done;
	byte_t rx_byte;
	logic rx_valid;

	port_decode port_decode_i (.clk(clk), .interrupt_rst(interrupt_rst), .port_id(port_id),
		.write_strobe(write_strobe), .read_strobe(read_strobe), .out_port(out_port),
		.port_req(port_req));

	port_regs port_regs_i (.clk(clk), .interrupt_rst(interrupt_rst), .port_req(port_req),
		.ext_data_in(ext_data_in), .rx_byte(rx_byte), .rx_valid(rx_valid),
		.tx_done(tx_done), .ext_int(ext_int), .tx_start(tx_start), .tx_byte(tx_byte),
		.in_port(in_port), .interrupt(interrupt));

	uart_rx #(.clk_freq(clk_freq), .baud_rate(baud_rate)) uart_rx_i (.clk(clk),
		.interrupt_rst(interrupt_rst), .serial_in(serial_in), .rx_byte(rx_byte),
		.rx_valid(rx_valid));

	uart_tx #(.clk_freq(clk_freq), .baud_rate(baud_rate)) uart_tx_i (.clk(clk),
		.interrupt_rst(interrupt_rst), .tx_start(tx_start), .tx_byte(tx_byte),
		.serial_out(serial_out), .tx_done(tx_done));

endmodule

// File: hdl/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
	parameter int clk_freq = 50_000_000,
	parameter int baud_rate = 115_200
) (
	input logic clk,
	input logic interrupt_rst,
	input logic serial_in,
	output uart_io_pkg::byte_t rx_byte,
	output logic rx_valid
);
	import uart_io_pkg::*;

	// clocks per bit
	localparam int BIT_CYCLES = clk_freq / baud_rate;
	localparam int CNT_W = $clog2(BIT_CYCLES);
	typedef logic [CNT_W-1:0] count_t;
	// half a bit to the start bit middle
	localparam count_t HALF_LOAD = count_t'(BIT_CYCLES / 2 - 1);
	localparam count_t BIT_LOAD = count_t'(BIT_CYCLES - 1);
	// index 0 start, 1..8 data, 9 stop
	localparam logic [3:0] STOP_IDX = 4'd9;

	rx_state_t state;
	count_t cnt;
	logic [3:0] bit_idx;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic start_edge;
	logic bit_tick;

	// two-flop synchroniser, extra stage for edge detect
	// idle line is high
	always_ff @(posedge clk) begin
		if (interrupt_rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= serial_in;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign start_edge = rx_prev && !rx_sync;
	// mid-bit sample point
	assign bit_tick = (state == RX_SHIFT) && (cnt == '0);

	always_ff @(posedge clk) begin
		if (interrupt_rst) begin
			state <= RX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				RX_IDLE: begin
					cnt <= HALF_LOAD;
					bit_idx <= '0;
					if (start_edge) begin
						state <= RX_SHIFT;
					end
				end
				RX_SHIFT: begin
					if (!bit_tick) begin
						cnt <= cnt - 1'b1;
					end else begin
						cnt <= BIT_LOAD;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == '0 && rx_sync) begin
							// glitch, start bit gone by its middle
							state <= RX_IDLE;
						end else if (bit_idx == STOP_IDX) begin
							// low stop bit drops the frame
							state <= rx_sync ? RX_DONE : RX_IDLE;
						end
					end
				end
				RX_DONE: state <= RX_IDLE;
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data bits shift in lsb first
	always_ff @(posedge clk) begin
		if (bit_tick && bit_idx != '0 && bit_idx != STOP_IDX) begin
			rx_byte <= {rx_sync, rx_byte[7:1]};
		end
	end

	assign rx_valid = (state == RX_DONE);

	// single-cycle strobe per frame
	assert property (@(posedge clk) disable iff (interrupt_rst)
		rx_valid |=> !rx_valid);

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
	parameter int clk_freq = 50_000_000,
	parameter int baud_rate = 115_200
) (
	input logic clk,
	input logic interrupt_rst,
	input logic tx_start,
	input uart_io_pkg::byte_t tx_byte,
	output logic serial_out,
	output logic tx_done
);
	import uart_io_pkg::*;

	// clocks per bit
	localparam int BIT_CYCLES = clk_freq / baud_rate;
	localparam int CNT_W = $clog2(BIT_CYCLES);
	typedef logic [CNT_W-1:0] count_t;
	localparam count_t BIT_LOAD = count_t'(BIT_CYCLES - 1);
	// stop bit is the tenth
	localparam logic [3:0] LAST_IDX = 4'd9;

	tx_state_t state;
	count_t cnt;
	logic [3:0] bit_idx;
	// frame shifter with bit 0 on the line
	logic [9:0] frame;
	logic bit_end;

	assign bit_end = (cnt == '0);
	assign serial_out = frame[0];

	always_ff @(posedge clk) begin
		if (interrupt_rst) begin
			state <= TX_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			// line idles high
			frame <= '1;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (tx_start) begin
						// stop bit, data and start bit from msb down
						frame <= {1'b1, tx_byte, 1'b0};
						cnt <= BIT_LOAD;
						bit_idx <= '0;
						state <= TX_SHIFT;
					end
				end
				TX_SHIFT: begin
					if (!bit_end) begin
						cnt <= cnt - 1'b1;
					end else begin
						cnt <= BIT_LOAD;
						// ones fill in behind the frame
						frame <= {1'b1, frame[9:1]};
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == LAST_IDX) begin
							state <= TX_IDLE;
							tx_done <= 1'b1;
						end
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// idle line stays at the stop level
	assert property (@(posedge clk) disable iff (interrupt_rst)
		(state == TX_IDLE) |-> serial_out);

endmodule

// File: run.sh
#!/bin/sh
# build with Verilator, run, then decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ns --top-module uart_io_tb \
	-f verilog.f -o uart_io_sim \
	&& ./obj_dir/uart_io_sim > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "Result: PASSED" sim.log 2>/dev/null \
	&& echo "simulation run ok" \
	|| { echo "simulation run not ok"; exit 1; }

// File: testbench/uart_io_tb.sv
`timescale 1ns/1ns

module uart_io_tb;
	import uart_io_pkg::*;

	// 1.6 MHz over 100 kbaud, 16 clocks per bit
	localparam int clk_freq = 1_600_000;
	localparam int baud_rate = 100_000;
	localparam int bit_cycles = clk_freq / baud_rate;
	localparam int rx_frames = 20;
	localparam int tx_frames = 20;
	// 10 bits per frame, double margin, plus slack for bus traffic
	localparam int cycle_limit = (rx_frames + tx_frames) * 10 * bit_cycles * 2 + 2000;

	logic clk;
	logic interrupt_rst;
	port_addr_t port_id;
	logic write_strobe;
	logic read_strobe;
	byte_t out_port;
	byte_t ext_data_in;
	logic serial_in;
	logic ext_int;
	byte_t in_port;
	logic serial_out;
	logic interrupt;

	// reference model of the register block
	byte_t model_hold;
	logic model_ready;
	logic model_busy;
	irq_flags_t model_irq;
	int cycle_count = 0;

	uart_io_top #(.clk_freq(clk_freq), .baud_rate(baud_rate)) uart_io_top_i (.clk(clk),
		.interrupt_rst(interrupt_rst), .port_id(port_id), .write_strobe(write_strobe),
		.read_strobe(read_strobe), .out_port(out_port), .ext_data_in(ext_data_in),
		.serial_in(serial_in), .ext_int(ext_int), .in_port(in_port),
		.serial_out(serial_out), .interrupt(interrupt));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// hard stop if a wait loop never ends
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: run still going after %0d clock cycles", cycle_count);
			$display("Result: FAILED");
			$fatal(1, "simulation stopped on timeout");
		end
	end

	// step to 1 ns past the next rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is 0x%02h, expected 0x%02h", name, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "simulation stopped at first mismatch");
		end
	endtask

	// one strobe cycle, data comes back two edges later
	task automatic read_port(input port_addr_t addr, input byte_t expected,
		input string name);
		port_id = addr;
		read_strobe = 1'b1;
		next_cycle();
		read_strobe = 1'b0;
		next_cycle();
		// reading the uart port consumes the held byte
		if (addr == PORT_UART) begin
			model_ready = 1'b0;
		end
		check_value(name, in_port, expected);
	endtask

	task automatic write_port(input port_addr_t addr, input byte_t data);
		port_id = addr;
		out_port = data;
		write_strobe = 1'b1;
		next_cycle();
		write_strobe = 1'b0;
	endtask

	task automatic wait_interrupt();
		while (interrupt !== 1'b1) begin
			next_cycle();
		end
	endtask

	// clear write, line must drop within two cycles
	task automatic clear_irq();
		write_port(PORT_IRQ, byte_t'($urandom));
		model_irq = '0;
		// a byte still waiting raises the rx flag again
		if (model_ready) begin
			model_irq[IRQ_RX] = 1'b1;
		end
		repeat (2) next_cycle();
		check_value("interrupt", {7'b0, interrupt}, {7'b0, |model_irq[5:0]});
	endtask

	// 8N1 frame onto serial_in, lsb first
	task automatic send_frame(input byte_t data);
		logic [9:0] bits;
		bits = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			serial_in = bits[i];
			repeat (bit_cycles) next_cycle();
		end
	endtask

	// decode one frame from serial_out at mid-bit
	task automatic watch_frame(input byte_t expected);
		byte_t data;
		while (serial_out !== 1'b0) begin
			next_cycle();
		end
		// already one cycle into the start bit
		repeat (bit_cycles / 2 - 1) next_cycle();
		check_value("serial_out start bit", {7'b0, serial_out}, 8'h00);
		for (int i = 0; i < 8; i++) begin
			repeat (bit_cycles) next_cycle();
			data[i] = serial_out;
		end
		repeat (bit_cycles) next_cycle();
		check_value("serial_out stop bit", {7'b0, serial_out}, 8'h01);
		check_value("serial_out data", data, expected);
	endtask

	task automatic receive_test(input int count);
		byte_t data;
		for (int n = 0; n < count; n++) begin
			data = byte_t'($urandom);
			send_frame(data);
			wait_interrupt();
			model_hold = data;
			model_ready = 1'b1;
			model_irq[IRQ_RX] = 1'b1;
			read_port(PORT_IRQ, model_irq, "in_port irq");
			read_port(PORT_UART, model_hold, "in_port uart");
			clear_irq();
		end
	endtask

	task automatic transmit_test(input int count);
		byte_t data;
		byte_t extra;
		for (int n = 0; n < count; n++) begin
			data = byte_t'($urandom);
			extra = byte_t'($urandom);
			write_port(PORT_UART, data);
			model_busy = 1'b1;
			fork
				watch_frame(data);
				begin
					// dropped, transmitter already busy
					write_port(PORT_UART, extra);
					read_port(PORT_STATUS, {7'b0, model_busy}, "in_port status");
				end
			join
			// tx done flag raises the line
			wait_interrupt();
			model_busy = 1'b0;
			model_irq[IRQ_TX] = 1'b1;
			read_port(PORT_STATUS, {7'b0, model_busy}, "in_port status");
			read_port(PORT_IRQ, model_irq, "in_port irq");
			clear_irq();
			// line stays idle, no second frame
			repeat (2 * bit_cycles) begin
				next_cycle();
				check_value("serial_out idle", {7'b0, serial_out}, 8'h01);
			end
		end
	endtask

	task automatic ext_irq_test();
		ext_int = 1'b1;
		next_cycle();
		ext_int = 1'b0;
		wait_interrupt();
		model_irq[IRQ_EXT] = 1'b1;
		read_port(PORT_IRQ, model_irq, "in_port irq");
		// flag holds long after the pulse
		repeat (4 * bit_cycles) next_cycle();
		check_value("interrupt", {7'b0, interrupt}, 8'h01);
		read_port(PORT_IRQ, model_irq, "in_port irq");
		clear_irq();
		read_port(PORT_IRQ, model_irq, "in_port irq");
	endtask

	task automatic decode_test(input int count);
		port_addr_t addr;
		byte_t data;
		port_addr_t gap_ports[5];
		gap_ports = '{8'h01, 8'h02, 8'h04, 8'h05, 8'h06};
		for (int n = 0; n < count; n++) begin
			// external window passes ext_data_in
			addr = port_addr_t'($urandom_range(int'(PORT_EXT_HI), int'(PORT_EXT_LO)));
			data = byte_t'($urandom);
			ext_data_in = data;
			read_port(addr, data, "in_port ext");
			// old ram range now unmapped
			addr = port_addr_t'($urandom_range(255, 128));
			read_port(addr, 8'hff, "in_port unmapped high");
		end
		foreach (gap_ports[i]) begin
			read_port(gap_ports[i], 8'hff, "in_port unmapped low");
		end
	endtask

	initial begin
		void'($urandom(14));
		interrupt_rst = 1'b1;
		port_id = '0;
		write_strobe = 1'b0;
		read_strobe = 1'b0;
		out_port = '0;
		ext_data_in = '0;
		serial_in = 1'b1;
		ext_int = 1'b0;
		model_hold = '0;
		model_ready = 1'b0;
		model_busy = 1'b0;
		model_irq = '0;
		repeat (5) @(posedge clk);
		#1;
		interrupt_rst = 1'b0;

		// idle state after reset
		check_value("serial_out", {7'b0, serial_out}, 8'h01);
		check_value("interrupt", {7'b0, interrupt}, 8'h00);
		read_port(PORT_STATUS, 8'h00, "in_port status");
		read_port(PORT_IRQ, 8'h00, "in_port irq");

		receive_test(rx_frames);
		transmit_test(tx_frames);
		ext_irq_test();
		decode_test(8);

		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: verilog.f
hdl/uart_io_pkg.sv
hdl/port_decode.sv
hdl/port_regs.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_io_top.sv
testbench/uart_io_tb.sv
